/* rtl/tcp_mem_settings.svh */
`ifndef TCP_MEM_SETTINGS_SVH
`define TCP_MEM_SETTINGS_SVH

// engine side beat width
`define TCP_NARROW_WIDTH 64

// memory side word width
`define TCP_WIDE_WIDTH 512

// narrow beats per memory word
`define TCP_LANES 8

// rx bypass buffer entries
`define TCP_RX_BUFFER_DEPTH 1024

// occupancy count reported to the engine
`define TCP_COUNT_WIDTH 16

`endif

/* rtl/tcp_mem_pkg.sv */
`include "tcp_mem_settings.svh"

package tcp_mem_pkg;

  // engine side stream
  typedef logic [`TCP_NARROW_WIDTH-1:0]   narrow_data_t; // one engine beat
  typedef logic [`TCP_NARROW_WIDTH/8-1:0] narrow_keep_t; // byte enables of a beat

  // memory side stream
  typedef logic [`TCP_WIDE_WIDTH-1:0]     wide_data_t;   // one memory word
  typedef logic [`TCP_WIDE_WIDTH/8-1:0]   wide_keep_t;   // byte enables of a word

  // engine buffer command, addr in 63..32, len in 22..0
  typedef logic [71:0]                    engine_cmd_t;

  // memory command fields
  typedef logic [63:0]                    mem_addr_t;    // byte address
  typedef logic [31:0]                    mem_len_t;     // byte count

  // rx buffer fill level
  typedef logic [`TCP_COUNT_WIDTH-1:0]    buf_count_t;

  // lane select within a memory word
  typedef logic [$clog2(`TCP_LANES)-1:0]  lane_idx_t;

endpackage

/* rtl/axis_if.sv */
`timescale 1ns/1ps

interface axis_if #(
  parameter int WIDTH = 64
);

  localparam int KEEP_W = WIDTH / 8; // one enable per byte

  logic [WIDTH-1:0]  data;
  logic [KEEP_W-1:0] keep;
  logic              last;  // final beat of a packet
  logic              valid;
  logic              ready;

  modport source (
    output data,
    output keep,
    output last,
    output valid,
    input  ready
  );

  modport sink (
    input  data,
    input  keep,
    input  last,
    input  valid,
    output ready
  );

endinterface

/* rtl/axis_upsizer.sv */
`timescale 1ns/1ps
`include "tcp_mem_settings.svh"

module axis_upsizer
  import tcp_mem_pkg::*;
(
  input  logic   net_clk,
  input  logic   net_aresetn,
  axis_if.sink   narrow,
  axis_if.source wide
);

  localparam int NW        = `TCP_NARROW_WIDTH;
  localparam int KW        = NW / 8;
  localparam int LAST_LANE = `TCP_LANES - 1;

  lane_idx_t  lane_idx;     // next lane to fill
  wide_data_t word_data;    // word under assembly
  wide_keep_t word_keep;
  logic       word_last;
  logic       full;         // finished word waiting for memory
  logic       narrow_fire;
  logic       wide_fire;
  logic       closing;      // this beat ends the word

  // one word in flight, input stalls until it leaves
  assign narrow.ready = !full;
  assign narrow_fire  = narrow.valid && !full;
  assign wide_fire    = full && wide.ready;
  assign closing      = narrow.last || (lane_idx == lane_idx_t'(LAST_LANE));

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      lane_idx <= '0;
      full     <= 1'b0;
    end else begin
      if (narrow_fire) begin
        if (closing) begin
          lane_idx <= '0;          // restart at lane 0 for next word
          full     <= 1'b1;
        end else begin
          lane_idx <= lane_idx + 1'b1;
        end
      end else if (wide_fire) begin
        full <= 1'b0;              // word taken by memory
      end
    end
  end

  always_ff @(posedge net_clk) begin
    if (narrow_fire) begin
      if (lane_idx == '0) begin
        word_data <= wide_data_t'(narrow.data); // fresh word, upper lanes zeroed
        word_keep <= wide_keep_t'(narrow.keep); // unfilled lanes stay disabled
      end else begin
        word_data[lane_idx*NW +: NW] <= narrow.data;
        word_keep[lane_idx*KW +: KW] <= narrow.keep;
      end
      word_last <= narrow.last;    // only the closing beat matters
    end
  end

  assign wide.valid = full;
  assign wide.data  = word_data;
  assign wide.keep  = word_keep;
  assign wide.last  = word_last;

  // a held word must not be overwritten by the next packet
  lane_hold_a: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    full |=> $stable(lane_idx))
    else $error("upsizer lane index moved while a word was held");

endmodule

/* rtl/axis_downsizer.sv */
`timescale 1ns/1ps
`include "tcp_mem_settings.svh"

module axis_downsizer
  import tcp_mem_pkg::*;
(
  input  logic   net_clk,
  input  logic   net_aresetn,
  axis_if.sink   wide,
  axis_if.source narrow
);

  localparam int NW = `TCP_NARROW_WIDTH;
  localparam int KW = NW / 8;

  wide_data_t word_data;    // held memory word
  wide_keep_t word_keep;
  logic       word_last;
  logic       full;
  lane_idx_t  lane_idx;     // lane now on the narrow side
  lane_idx_t  last_lane;    // highest lane with any keep bit
  logic       final_beat;
  logic       narrow_fire;
  logic       wide_fire;

  // keep is filled from lane 0 up, so the top used lane ends the word
  always_comb begin : find_last_lane
    last_lane = '0;
    for (int i = 0; i < `TCP_LANES; i++) begin
      if (|word_keep[i*KW +: KW]) begin
        last_lane = lane_idx_t'(i);
      end
    end
  end

  assign final_beat  = (lane_idx == last_lane);
  assign narrow_fire = full && narrow.ready;
  assign wide.ready  = !full || (narrow_fire && final_beat); // refill behind last beat
  assign wide_fire   = wide.valid && wide.ready;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      full     <= 1'b0;
      lane_idx <= '0;
    end else begin
      if (wide_fire) begin
        full     <= 1'b1;          // new word, start at lane 0
        lane_idx <= '0;
      end else if (narrow_fire) begin
        if (final_beat) begin
          full     <= 1'b0;
          lane_idx <= '0;
        end else begin
          lane_idx <= lane_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge net_clk) begin
    if (wide_fire) begin
      word_data <= wide.data;
      word_keep <= wide.keep;
      word_last <= wide.last;
    end
  end

  assign narrow.valid = full;
  assign narrow.data  = word_data[lane_idx*NW +: NW];
  assign narrow.keep  = word_keep[lane_idx*KW +: KW];
  assign narrow.last  = word_last && final_beat; // packet end only on the used top lane

  // memory must never hand over a word with an empty lane 0
  beat_keep_a: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    narrow.valid |-> (narrow.keep != '0))
    else $error("downsizer emitted a beat with no enabled bytes");

endmodule

/* rtl/rx_buffer_fifo.sv */
`timescale 1ns/1ps
`include "tcp_mem_settings.svh"

module rx_buffer_fifo
  import tcp_mem_pkg::*;
(
  input  logic       net_clk,
  input  logic       net_aresetn,
  axis_if.sink       wr,
  axis_if.source     rd,
  output buf_count_t count
);

  localparam int DEPTH = `TCP_RX_BUFFER_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  narrow_data_t     mem_data [DEPTH];
  narrow_keep_t     mem_keep [DEPTH];
  logic             mem_last [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  buf_count_t       occ;        // entries held right now
  buf_count_t       count_q1;   // first delay stage
  buf_count_t       count_q2;   // value seen by the engine
  logic             wr_fire;
  logic             rd_fire;

  assign wr.ready = (occ != buf_count_t'(DEPTH)); // stall when full
  assign rd.valid = (occ != '0);
  assign wr_fire  = wr.valid && wr.ready;
  assign rd_fire  = rd.valid && rd.ready;

  // storage
  always_ff @(posedge net_clk) begin
    if (wr_fire) begin
      mem_data[wr_ptr] <= wr.data;
      mem_keep[wr_ptr] <= wr.keep;
      mem_last[wr_ptr] <= wr.last;
    end
  end

  // first word falls through, head entry always on the output
  assign rd.data = mem_data[rd_ptr];
  assign rd.keep = mem_keep[rd_ptr];
  assign rd.last = mem_last[rd_ptr];

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;   // idle or write and read together
      endcase
    end
  end

  // two register stages before the count reaches the engine
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      count_q1 <= '0;
      count_q2 <= '0;
    end else begin
      count_q1 <= occ;
      count_q2 <= count_q1;
    end
  end

  assign count = count_q2;

  count_range_a: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    count <= buf_count_t'(DEPTH))
    else $error("rx buffer count above depth");

  full_no_write_a: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    (occ == buf_count_t'(DEPTH)) |=> (wr_ptr == $past(wr_ptr)))
    else $error("rx buffer written while full");

endmodule

/* rtl/tcp_mem_path.sv */
`timescale 1ns/1ps
`include "tcp_mem_settings.svh"

module tcp_mem_path
  import tcp_mem_pkg::*;
(
  input  logic         net_clk,
  input  logic         net_aresetn,
  // tx buffer write command
  input  logic         txwrite_cmd_valid,
  output logic         txwrite_cmd_ready,
  input  engine_cmd_t  txwrite_cmd_data,
  output logic         mem_write_cmd_valid,
  input  logic         mem_write_cmd_ready,
  output mem_addr_t    mem_write_cmd_address,
  output mem_len_t     mem_write_cmd_length,
  // tx buffer read command
  input  logic         txread_cmd_valid,
  output logic         txread_cmd_ready,
  input  engine_cmd_t  txread_cmd_data,
  output logic         mem_read_cmd_valid,
  input  logic         mem_read_cmd_ready,
  output mem_addr_t    mem_read_cmd_address,
  output mem_len_t     mem_read_cmd_length,
  // tx write data, engine to memory
  input  logic         txwrite_data_valid,
  output logic         txwrite_data_ready,
  input  narrow_data_t txwrite_data_data,
  input  narrow_keep_t txwrite_data_keep,
  input  logic         txwrite_data_last,
  output logic         mem_write_data_valid,
  input  logic         mem_write_data_ready,
  output wide_data_t   mem_write_data_data,
  output wide_keep_t   mem_write_data_keep,
  output logic         mem_write_data_last,
  // tx read data, memory to engine
  input  logic         mem_read_data_valid,
  output logic         mem_read_data_ready,
  input  wide_data_t   mem_read_data_data,
  input  wide_keep_t   mem_read_data_keep,
  input  logic         mem_read_data_last,
  output logic         txread_data_valid,
  input  logic         txread_data_ready,
  output narrow_data_t txread_data_data,
  output narrow_keep_t txread_data_keep,
  output logic         txread_data_last,
  // rx bypass buffer
  input  logic         rxwrite_data_valid,
  output logic         rxwrite_data_ready,
  input  narrow_data_t rxwrite_data_data,
  input  narrow_keep_t rxwrite_data_keep,
  input  logic         rxwrite_data_last,
  output logic         rxread_data_valid,
  input  logic         rxread_data_ready,
  output narrow_data_t rxread_data_data,
  output narrow_keep_t rxread_data_keep,
  output logic         rxread_data_last,
  output buf_count_t   rx_buffer_count
);

  // engine command fields, zero-extended to memory width
  function automatic mem_addr_t cmd_address(input engine_cmd_t cmd);
    return mem_addr_t'(cmd[63:32]);
  endfunction

  function automatic mem_len_t cmd_length(input engine_cmd_t cmd);
    return mem_len_t'(cmd[22:0]);
  endfunction

  // command paths, handshake passes straight through
  assign mem_write_cmd_valid   = txwrite_cmd_valid;
  assign txwrite_cmd_ready     = mem_write_cmd_ready;
  assign mem_write_cmd_address = cmd_address(txwrite_cmd_data);
  assign mem_write_cmd_length  = cmd_length(txwrite_cmd_data);

  assign mem_read_cmd_valid    = txread_cmd_valid;
  assign txread_cmd_ready      = mem_read_cmd_ready;
  assign mem_read_cmd_address  = cmd_address(txread_cmd_data);
  assign mem_read_cmd_length   = cmd_length(txread_cmd_data);

  axis_if #(.WIDTH(`TCP_NARROW_WIDTH)) txwrite_if ();  // engine to upsizer
  axis_if #(.WIDTH(`TCP_WIDE_WIDTH))   memwrite_if (); // upsizer to memory
  axis_if #(.WIDTH(`TCP_WIDE_WIDTH))   memread_if ();  // memory to downsizer
  axis_if #(.WIDTH(`TCP_NARROW_WIDTH)) txread_if ();   // downsizer to engine
  axis_if #(.WIDTH(`TCP_NARROW_WIDTH)) rxwrite_if ();  // engine into rx buffer
  axis_if #(.WIDTH(`TCP_NARROW_WIDTH)) rxread_if ();   // rx buffer to engine

  assign txwrite_if.valid     = txwrite_data_valid;
  assign txwrite_if.data      = txwrite_data_data;
  assign txwrite_if.keep      = txwrite_data_keep;
  assign txwrite_if.last      = txwrite_data_last;
  assign txwrite_data_ready   = txwrite_if.ready;

  assign mem_write_data_valid = memwrite_if.valid;
  assign mem_write_data_data  = memwrite_if.data;
  assign mem_write_data_keep  = memwrite_if.keep;
  assign mem_write_data_last  = memwrite_if.last;
  assign memwrite_if.ready    = mem_write_data_ready;

  assign memread_if.valid     = mem_read_data_valid;
  assign memread_if.data      = mem_read_data_data;
  assign memread_if.keep      = mem_read_data_keep;
  assign memread_if.last      = mem_read_data_last;
  assign mem_read_data_ready  = memread_if.ready;

  assign txread_data_valid    = txread_if.valid;
  assign txread_data_data     = txread_if.data;
  assign txread_data_keep     = txread_if.keep;
  assign txread_data_last     = txread_if.last;
  assign txread_if.ready      = txread_data_ready;

  assign rxwrite_if.valid     = rxwrite_data_valid;
  assign rxwrite_if.data      = rxwrite_data_data;
  assign rxwrite_if.keep      = rxwrite_data_keep;
  assign rxwrite_if.last      = rxwrite_data_last;
  assign rxwrite_data_ready   = rxwrite_if.ready;

  assign rxread_data_valid    = rxread_if.valid;
  assign rxread_data_data     = rxread_if.data;
  assign rxread_data_keep     = rxread_if.keep;
  assign rxread_data_last     = rxread_if.last;
  assign rxread_if.ready      = rxread_data_ready;

  axis_upsizer txwrite_upsizer_i (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .narrow      (txwrite_if.sink),
    .wide        (memwrite_if.source)
  );

  axis_downsizer txread_downsizer_i (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .wide        (memread_if.sink),
    .narrow      (txread_if.source)
  );

  rx_buffer_fifo rx_buffer_i (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .wr          (rxwrite_if.sink),
    .rd          (rxread_if.source),
    .count       (rx_buffer_count)
  );

endmodule

/* tb/tcp_mem_path_tb.sv */
`timescale 1ns/1ps
`include "tcp_mem_settings.svh"

module tcp_mem_path_tb
  import tcp_mem_pkg::*;
();

  localparam int K_CMD = 0, K_UP = 1, K_DOWN = 2, K_RX = 3;
  localparam int NT = 11;
  // name, kind, beat count, back-pressure
  string t_name [NT] = '{"cmd_random", "up_1", "up_7", "up_8", "up_9", "up_20",
                         "down_lanes", "rx_fill_drain", "up_bp", "down_bp", "rx_bp"};
  int    t_kind [NT] = '{K_CMD, K_UP, K_UP, K_UP, K_UP, K_UP, K_DOWN, K_RX, K_UP, K_DOWN, K_RX};
  int    t_beats[NT] = '{16, 1, 7, 8, 9, 20, 8, 20, 20, 8, 20};
  bit    t_bp   [NT] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1};

  logic net_clk, net_aresetn;
  logic txwrite_cmd_valid, txwrite_cmd_ready, txread_cmd_valid, txread_cmd_ready;
  engine_cmd_t txwrite_cmd_data, txread_cmd_data;
  logic mem_write_cmd_valid, mem_write_cmd_ready, mem_read_cmd_valid, mem_read_cmd_ready;
  mem_addr_t mem_write_cmd_address, mem_read_cmd_address;
  mem_len_t mem_write_cmd_length, mem_read_cmd_length;
  logic txwrite_data_valid, txwrite_data_ready, txwrite_data_last;
  narrow_data_t txwrite_data_data;
  narrow_keep_t txwrite_data_keep;
  logic mem_write_data_valid, mem_write_data_ready, mem_write_data_last;
  wide_data_t mem_write_data_data, mem_read_data_data;
  wide_keep_t mem_write_data_keep, mem_read_data_keep;
  logic mem_read_data_valid, mem_read_data_ready, mem_read_data_last;
  logic txread_data_valid, txread_data_ready, txread_data_last;
  narrow_data_t txread_data_data, rxwrite_data_data, rxread_data_data;
  narrow_keep_t txread_data_keep, rxwrite_data_keep, rxread_data_keep;
  logic rxwrite_data_valid, rxwrite_data_ready, rxwrite_data_last;
  logic rxread_data_valid, rxread_data_ready, rxread_data_last;
  buf_count_t rx_buffer_count;
  int errors = 0;
  int checks = 0;

  tcp_mem_path tcp_mem_path_i (.*);

  initial begin
    net_clk = 1'b0;
    forever #4 net_clk = ~net_clk; // 8 ns period
  end

  task automatic check_value(input string name, input string what,
                             input logic [511:0] exp, input logic [511:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Mismatch %s %s expected %0h actual %0h", name, what, exp, act);
    end
  endtask

  task automatic run_cmd(input string name, input int n);
    engine_cmd_t cw, cr;
    for (int i = 0; i <= n; i++) begin
      @(posedge net_clk);
      if (i > 0) begin // outputs settled from the previous drive
        check_value(name, "write address", {32'b0, cw[63:32]}, mem_write_cmd_address);
        check_value(name, "write length", {9'b0, cw[22:0]}, mem_write_cmd_length);
        check_value(name, "read address", {32'b0, cr[63:32]}, mem_read_cmd_address);
        check_value(name, "read length", {9'b0, cr[22:0]}, mem_read_cmd_length);
        check_value(name, "write valid", txwrite_cmd_valid, mem_write_cmd_valid);
        check_value(name, "write ready", mem_write_cmd_ready, txwrite_cmd_ready);
        check_value(name, "read valid", txread_cmd_valid, mem_read_cmd_valid);
        check_value(name, "read ready", mem_read_cmd_ready, txread_cmd_ready);
      end
      cw = {8'($urandom()), $urandom(), $urandom()};
      cr = {8'($urandom()), $urandom(), $urandom()};
      txwrite_cmd_data    <= (i < n) ? cw : '0;
      txread_cmd_data     <= (i < n) ? cr : '0;
      txwrite_cmd_valid   <= (i < n) && $urandom_range(1, 0);
      txread_cmd_valid    <= (i < n) && $urandom_range(1, 0);
      mem_write_cmd_ready <= $urandom_range(1, 0);
      mem_read_cmd_ready  <= $urandom_range(1, 0);
    end
  endtask

  task automatic run_upsizer(input string name, input int n, input bit bp);
    narrow_data_t beats[$];
    wide_data_t e_data[$];
    wide_keep_t e_keep[$];
    logic e_last[$];
    wide_data_t wd;
    wide_keep_t wk;
    int sent = 0;
    int got = 0;
    for (int i = 0; i < n; i++) beats.push_back({$urandom(), $urandom()});
    for (int s = 0; s < n; s += 8) begin // lane k holds beat s+k
      wd = '0;
      wk = '0;
      for (int k = 0; k < 8 && s + k < n; k++) begin
        wd[k*64 +: 64] = beats[s+k];
        wk[k*8 +: 8]   = (s + k == n - 1) ? 8'h3f : 8'hff;
      end
      e_data.push_back(wd);
      e_keep.push_back(wk);
      e_last.push_back(s + 8 >= n);
    end
    while (sent < n || got < e_data.size()) begin
      @(posedge net_clk);
      if (mem_write_data_valid && mem_write_data_ready) begin
        assert (got < e_data.size()) else begin
          errors++;
          $display("%s: upsizer sent more wide words than expected", name);
        end
        if (got < e_data.size()) begin
          check_value(name, "wide data", e_data[got], mem_write_data_data);
          check_value(name, "wide keep", e_keep[got], mem_write_data_keep);
          check_value(name, "wide last", e_last[got], mem_write_data_last);
        end
        got++;
      end
      if (txwrite_data_valid && txwrite_data_ready) sent++;
      if (!(txwrite_data_valid && !txwrite_data_ready)) begin // hold a stalled beat
        txwrite_data_valid <= (sent < n) && (!bp || $urandom_range(1, 0));
        txwrite_data_data  <= (sent < n) ? beats[sent] : '0;
        txwrite_data_keep  <= (sent == n - 1) ? 8'h3f : 8'hff;
        txwrite_data_last  <= (sent == n - 1);
      end
      mem_write_data_ready <= !bp || ($urandom_range(3, 0) != 0);
    end
  endtask

  task automatic run_downsizer(input string name, input int n, input bit bp);
    wide_data_t w_data[$];
    wide_keep_t w_keep[$];
    logic w_last[$];
    narrow_data_t e_data[$];
    narrow_keep_t e_keep[$];
    logic e_last[$];
    wide_data_t wd;
    int sent = 0;
    int got = 0;
    for (int w = 1; w <= n; w++) begin // word w uses lanes 0..w-1
      for (int j = 0; j < 16; j++) wd[j*32 +: 32] = $urandom();
      w_data.push_back(wd);
      w_keep.push_back(wide_keep_t'((65'd1 << (8 * w)) - 1));
      w_last.push_back(w % 2);
      for (int k = 0; k < w; k++) begin
        e_data.push_back(wd[k*64 +: 64]);
        e_keep.push_back(8'hff);
        e_last.push_back((w % 2) && (k == w - 1));
      end
    end
    while (sent < n || got < e_data.size()) begin
      @(posedge net_clk);
      if (txread_data_valid && txread_data_ready) begin
        assert (got < e_data.size()) else begin
          errors++;
          $display("%s: downsizer sent more beats than expected", name);
        end
        if (got < e_data.size()) begin
          check_value(name, "narrow data", e_data[got], txread_data_data);
          check_value(name, "narrow keep", e_keep[got], txread_data_keep);
          check_value(name, "narrow last", e_last[got], txread_data_last);
        end
        got++;
      end
      if (mem_read_data_valid && mem_read_data_ready) sent++;
      if (!(mem_read_data_valid && !mem_read_data_ready)) begin
        mem_read_data_valid <= (sent < n) && (!bp || $urandom_range(1, 0));
        mem_read_data_data  <= (sent < n) ? w_data[sent] : '0;
        mem_read_data_keep  <= (sent < n) ? w_keep[sent] : '0;
        mem_read_data_last  <= (sent < n) ? w_last[sent] : 1'b0;
      end
      txread_data_ready <= !bp || ($urandom_range(3, 0) != 0);
    end
  endtask

  task automatic run_rx(input string name, input int n, input bit bp);
    narrow_data_t beats[$];
    narrow_keep_t keeps[$];
    int sent = 0;
    int got = 0;
    for (int i = 0; i < n; i++) beats.push_back({$urandom(), $urandom()});
    for (int i = 0; i < n; i++) keeps.push_back(8'($urandom()));
    rxread_data_ready <= 1'b0; // fill with the reader stalled
    while (sent < n) begin
      @(posedge net_clk);
      if (rxwrite_data_valid && rxwrite_data_ready) sent++;
      if (!(rxwrite_data_valid && !rxwrite_data_ready)) begin
        rxwrite_data_valid <= (sent < n) && (!bp || $urandom_range(1, 0));
        rxwrite_data_data  <= (sent < n) ? beats[sent] : '0;
        rxwrite_data_keep  <= (sent < n) ? keeps[sent] : '0;
        rxwrite_data_last  <= (sent == n - 1);
      end
    end
    repeat (4) @(posedge net_clk);
    check_value(name, "count after fill", n, rx_buffer_count);
    while (got < n) begin
      @(posedge net_clk);
      if (rxread_data_valid && rxread_data_ready) begin
        check_value(name, "rx data", beats[got], rxread_data_data);
        check_value(name, "rx keep", keeps[got], rxread_data_keep);
        check_value(name, "rx last", got == n - 1, rxread_data_last);
        got++;
      end
      rxread_data_ready <= (got < n) && (!bp || $urandom_range(1, 0));
    end
    repeat (4) @(posedge net_clk);
    check_value(name, "count after drain", 0, rx_buffer_count);
  endtask

  // watchdog scaled to the table length
  initial begin
    int limit = 1000;
    for (int i = 0; i < NT; i++) limit += t_beats[i] * 20;
    repeat (limit) @(posedge net_clk);
    $display("watchdog expired after %0d cycles, the test did not finish", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h2438_f0c8));
    {txwrite_cmd_valid, txread_cmd_valid, mem_write_cmd_ready, mem_read_cmd_ready} = '0;
    {txwrite_cmd_data, txread_cmd_data} = '0;
    {txwrite_data_valid, txwrite_data_last, txwrite_data_data, txwrite_data_keep} = '0;
    {mem_write_data_ready, txread_data_ready, rxread_data_ready} = '0;
    {mem_read_data_valid, mem_read_data_last, mem_read_data_data, mem_read_data_keep} = '0;
    {rxwrite_data_valid, rxwrite_data_last, rxwrite_data_data, rxwrite_data_keep} = '0;
    net_aresetn = 1'b0;
    repeat (5) @(posedge net_clk);
    net_aresetn <= 1'b1;
    @(posedge net_clk);
    check_value("reset", "valid outputs", '0, {mem_write_cmd_valid, mem_read_cmd_valid,
                mem_write_data_valid, txread_data_valid, rxread_data_valid});
    check_value("reset", "rx count", '0, rx_buffer_count);
    for (int t = 0; t < NT; t++) begin
      case (t_kind[t])
        K_CMD:   run_cmd(t_name[t], t_beats[t]);
        K_UP:    run_upsizer(t_name[t], t_beats[t], t_bp[t]);
        K_DOWN:  run_downsizer(t_name[t], t_beats[t], t_bp[t]);
        default: run_rx(t_name[t], t_beats[t], t_bp[t]);
      endcase
    end
    $display("tests %0d checks %0d errors %0d", NT, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+rtl
rtl/tcp_mem_pkg.sv
rtl/axis_if.sv
rtl/axis_upsizer.sv
rtl/axis_downsizer.sv
rtl/rx_buffer_fifo.sv
rtl/tcp_mem_path.sv
tb/tcp_mem_path_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
  --top-module tcp_mem_path_tb -o tcp_mem_path_sim

./obj_dir/tcp_mem_path_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "TEST RESULT: PASS" sim.log
